//--- hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // ============================
  // Major opcodes
  // ============================
  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_BRANCH = 7'b1100011
  } opcode_e;

  // R-type view used for ALU and multiplier function fields
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rtype_t;

  // B-type view with offset bits scattered around the register fields
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } btype_t;

  typedef union packed {
    rtype_t r;
    btype_t b;
  } inst_u;

  // ============================
  // Function codes
  // ============================
  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  typedef enum logic [2:0] {
    ADD_SUB = 3'b000,
    SLL     = 3'b001,
    SLT     = 3'b010,
    SLTU    = 3'b011,
    XOR     = 3'b100,
    SRL_SRA = 3'b101,
    OR      = 3'b110,
    AND     = 3'b111
  } alu_funct3_e;

  typedef enum logic [2:0] {
    MUL    = 3'b000,
    MULH   = 3'b001,
    MULHSU = 3'b010,
    MULHU  = 3'b011
  } mul_funct3_e;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_funct3_e;

endpackage

`default_nettype wire

//--- hw/exec_pkg.sv
`default_nettype none

package exec_pkg;

  import isa_pkg::*;

  // ============================
  // Core sizes
  // ============================
  localparam int XLEN       = 32;
  localparam int PHYS_REGS  = 128;
  localparam int ROB_DEPTH  = 64;
  localparam int MUL_STAGES = 3;

  typedef logic [XLEN-1:0]              xlen_t;
  typedef logic [$clog2(PHYS_REGS)-1:0] prf_tag_t;
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;

  // ============================
  // Stage words
  // ============================

  // Issue word with operands already read from the register file
  typedef struct packed {
    inst_u    inst;
    xlen_t    pc;
    xlen_t    src1_val;
    xlen_t    src2_val;
    prf_tag_t dest_tag;
    rob_idx_t rob_idx;
    logic     pred_taken;
  } issue_pkt_t;

  // Completion word toward the complete stage
  typedef struct packed {
    xlen_t    value;
    prf_tag_t dest_tag;
    rob_idx_t rob_idx;
    logic     is_branch;
    logic     taken;
    logic     mispred;
  } exec_result_t;

endpackage

`default_nettype wire

//--- hw/issue_router.sv
`timescale 1ns/1ps
`default_nettype none

module issue_router
  import exec_pkg::*, isa_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       issue_valid_i,
  input  issue_pkt_t issue_pkt_i,
  output logic       issue_ready_o,
  output logic       alu_valid_o,
  output logic       mul_valid_o,
  output issue_pkt_t pkt_o,
  input  logic       alu_ready_i,
  input  logic       mul_ready_i
);

  logic is_reg;
  logic is_branch;
  logic to_mul;
  logic to_alu;

  // Class decode from opcode and funct7
  assign is_reg    = (issue_pkt_i.inst.r.opcode == OP_REG);
  assign is_branch = (issue_pkt_i.inst.r.opcode == OP_BRANCH);
  assign to_mul    = is_reg && (issue_pkt_i.inst.r.funct7 == FUNCT7_MULDIV);
  assign to_alu    = (is_reg && !to_mul) || is_branch;

  assign alu_valid_o = issue_valid_i && to_alu;
  assign mul_valid_o = issue_valid_i && to_mul;

  // Both units see the same packet
  assign pkt_o = issue_pkt_i;

  // Unknown opcodes are swallowed, so ready stays high for them
  always_comb begin
    if (to_alu) begin
      issue_ready_o = alu_ready_i;
    end else if (to_mul) begin
      issue_ready_o = mul_ready_i;
    end else begin
      issue_ready_o = 1'b1;
    end
  end

  // One unit at most per issue slot
  a_one_target: assert property (
    @(posedge clock) disable iff (reset)
    !(alu_valid_o && mul_valid_o)
  ) else $error("router steered a packet to both units");

endmodule

`default_nettype wire

//--- hw/alu_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_branch_unit
  import exec_pkg::*, isa_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         in_valid_i,
  input  issue_pkt_t   pkt_i,
  output logic         in_ready_o,
  output logic         out_valid_o,
  output exec_result_t out_result_o,
  input  logic         out_ready_i
);

  xlen_t        op_a;
  xlen_t        op_b;
  logic [4:0]   shamt;
  logic [2:0]   f3;
  logic         alt;
  logic         is_branch;
  logic         taken;
  xlen_t        alu_val;
  xlen_t        br_offset;
  exec_result_t res_d;
  exec_result_t res_q;
  logic         valid_q;

  assign op_a      = pkt_i.src1_val;
  assign op_b      = pkt_i.src2_val;
  assign shamt     = pkt_i.src2_val[4:0];
  assign f3        = pkt_i.inst.r.funct3;
  assign alt       = (pkt_i.inst.r.funct7 == FUNCT7_ALT);
  assign is_branch = (pkt_i.inst.r.opcode == OP_BRANCH);

  // ============================
  // Register-register ALU
  // ============================
  always_comb begin
    alu_val = '0;
    case (alu_funct3_e'(f3))
      ADD_SUB: begin
        if (alt) begin
          alu_val = op_a - op_b;
        end else begin
          alu_val = op_a + op_b;
        end
      end
      SLL:  alu_val = op_a << shamt;
      SLT:  alu_val = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      SLTU: alu_val = {{(XLEN-1){1'b0}}, op_a < op_b};
      XOR:  alu_val = op_a ^ op_b;
      SRL_SRA: begin
        // Arithmetic shift for SRA, logical for SRL
        if (alt) begin
          alu_val = $signed(op_a) >>> shamt;
        end else begin
          alu_val = op_a >> shamt;
        end
      end
      OR:   alu_val = op_a | op_b;
      AND:  alu_val = op_a & op_b;
    endcase
  end

  // ============================
  // Branch resolution
  // ============================
  assign br_offset = {{(XLEN-12){pkt_i.inst.b.imm12}}, pkt_i.inst.b.imm11,
                      pkt_i.inst.b.imm10_5, pkt_i.inst.b.imm4_1, 1'b0};

  always_comb begin
    case (br_funct3_e'(f3))
      BEQ:     taken = (op_a == op_b);
      BNE:     taken = (op_a != op_b);
      BLT:     taken = ($signed(op_a) < $signed(op_b));
      BGE:     taken = ($signed(op_a) >= $signed(op_b));
      BLTU:    taken = (op_a < op_b);
      BGEU:    taken = (op_a >= op_b);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    res_d.dest_tag = pkt_i.dest_tag;
    res_d.rob_idx  = pkt_i.rob_idx;
    if (is_branch) begin
      res_d.value     = taken ? (pkt_i.pc + br_offset) : (pkt_i.pc + xlen_t'(4));
      res_d.is_branch = 1'b1;
      res_d.taken     = taken;
      res_d.mispred   = (taken != pkt_i.pred_taken);
    end else begin
      res_d.value     = alu_val;
      res_d.is_branch = 1'b0;
      res_d.taken     = 1'b0;
      res_d.mispred   = 1'b0;
    end
  end

  // Output register refills when empty or drained this cycle
  assign in_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid_i && in_ready_o) begin
      res_q <= res_d;
    end
  end

  assign out_valid_o  = valid_q;
  assign out_result_o = res_q;

  a_hold_stable: assert property (
    @(posedge clock) disable iff (reset)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_result_o)
  ) else $error("ALU result changed while stalled");

endmodule

`default_nettype wire

//--- hw/mul_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module mul_pipe
  import exec_pkg::*, isa_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         in_valid_i,
  input  issue_pkt_t   pkt_i,
  output logic         in_ready_o,
  output logic         out_valid_o,
  output exec_result_t out_result_o,
  input  logic         out_ready_i
);

  logic                       a_signed;
  logic                       b_signed;
  logic signed [XLEN:0]       ext_a;
  logic signed [XLEN:0]       ext_b;
  logic signed [2*XLEN+1:0]   product;
  exec_result_t               mul_res;
  logic [MUL_STAGES-1:0]      stage_valid;
  logic [MUL_STAGES-1:0]      stage_en;
  exec_result_t [MUL_STAGES-1:0] stage_data;
  logic                       in_fire;
  logic                       out_fire;
  logic [$clog2(MUL_STAGES+1):0] in_flight;

  // ============================
  // Operand extension and product
  // ============================
  always_comb begin
    case (mul_funct3_e'(pkt_i.inst.r.funct3))
      MULH: begin
        a_signed = 1'b1;
        b_signed = 1'b1;
      end
      MULHSU: begin
        a_signed = 1'b1;
        b_signed = 1'b0;
      end
      default: begin
        // MUL low word is the same for any signedness
        a_signed = 1'b0;
        b_signed = 1'b0;
      end
    endcase
  end

  assign ext_a   = {a_signed & pkt_i.src1_val[XLEN-1], pkt_i.src1_val};
  assign ext_b   = {b_signed & pkt_i.src2_val[XLEN-1], pkt_i.src2_val};
  assign product = ext_a * ext_b;

  always_comb begin
    mul_res.dest_tag  = pkt_i.dest_tag;
    mul_res.rob_idx   = pkt_i.rob_idx;
    mul_res.is_branch = 1'b0;
    mul_res.taken     = 1'b0;
    mul_res.mispred   = 1'b0;
    if (pkt_i.inst.r.funct3 == MUL) begin
      mul_res.value = product[XLEN-1:0];
    end else begin
      mul_res.value = product[2*XLEN-1:XLEN];
    end
  end

  // ============================
  // Stage enables
  // ============================
  // A stage moves when it is empty or everything below it can move
  always_comb begin
    logic all_full;
    for (int i = 0; i < MUL_STAGES; i++) begin
      all_full = 1'b1;
      for (int j = i; j < MUL_STAGES; j++) begin
        all_full = all_full & stage_valid[j];
      end
      stage_en[i] = !all_full || out_ready_i;
    end
  end

  assign in_ready_o = stage_en[0];

  always_ff @(posedge clock) begin
    if (reset) begin
      stage_valid <= '0;
    end else begin
      if (stage_en[0]) begin
        stage_valid[0] <= in_valid_i;
      end
      for (int i = 1; i < MUL_STAGES; i++) begin
        if (stage_en[i]) begin
          stage_valid[i] <= stage_valid[i-1];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (stage_en[0] && in_valid_i) begin
      stage_data[0] <= mul_res;
    end
    for (int i = 1; i < MUL_STAGES; i++) begin
      if (stage_en[i] && stage_valid[i-1]) begin
        stage_data[i] <= stage_data[i-1];
      end
    end
  end

  assign out_valid_o  = stage_valid[MUL_STAGES-1];
  assign out_result_o = stage_data[MUL_STAGES-1];

  // Operations accepted and not yet handed on
  assign in_fire  = in_valid_i && in_ready_o;
  assign out_fire = out_valid_o && out_ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      in_flight <= '0;
    end else if (in_fire && !out_fire) begin
      in_flight <= in_flight + 1'b1;
    end else if (!in_fire && out_fire) begin
      in_flight <= in_flight - 1'b1;
    end
  end

  a_in_flight: assert property (
    @(posedge clock) disable iff (reset)
    (in_flight <= MUL_STAGES) && ($countones(stage_valid) == in_flight)
  ) else $error("multiplier holds more operations than stages or lost one");

endmodule

`default_nettype wire

//--- hw/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter
  import exec_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         alu_valid_i,
  input  exec_result_t alu_result_i,
  output logic         alu_ready_o,
  input  logic         mul_valid_i,
  input  exec_result_t mul_result_i,
  output logic         mul_ready_o,
  output logic         result_valid_o,
  output exec_result_t result_o,
  input  logic         result_ready_i
);

  logic         load_en;
  logic         grant_alu;
  logic         grant_mul;
  logic         last_alu;
  logic         out_valid_q;
  exec_result_t out_q;

  // Output slot free or draining this cycle
  assign load_en = !out_valid_q || result_ready_i;

  // Round robin where the source not served last wins a tie
  always_comb begin
    grant_alu = 1'b0;
    grant_mul = 1'b0;
    if (load_en) begin
      if (alu_valid_i && mul_valid_i) begin
        grant_alu = !last_alu;
        grant_mul = last_alu;
      end else begin
        grant_alu = alu_valid_i;
        grant_mul = mul_valid_i;
      end
    end
  end

  assign alu_ready_o = grant_alu;
  assign mul_ready_o = grant_mul;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid_q <= 1'b0;
      last_alu    <= 1'b0;
    end else begin
      if (load_en) begin
        out_valid_q <= grant_alu || grant_mul;
      end
      if (grant_alu) begin
        last_alu <= 1'b1;
      end else if (grant_mul) begin
        last_alu <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (grant_alu) begin
      out_q <= alu_result_i;
    end else if (grant_mul) begin
      out_q <= mul_result_i;
    end
  end

  assign result_valid_o = out_valid_q;
  assign result_o       = out_q;

  a_single_grant: assert property (
    @(posedge clock) disable iff (reset)
    !(alu_ready_o && mul_ready_o)
  ) else $error("arbiter granted both units");

endmodule

`default_nettype wire

//--- hw/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top
  import exec_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         issue_valid_i,
  input  issue_pkt_t   issue_pkt_i,
  output logic         issue_ready_o,
  output logic         result_valid_o,
  output exec_result_t result_o,
  input  logic         result_ready_i
);

  // Router to units
  issue_pkt_t   unit_pkt;
  logic         alu_valid;
  logic         alu_ready;
  logic         mul_valid;
  logic         mul_ready;

  // Units to arbiter
  logic         alu_res_valid;
  logic         alu_res_ready;
  exec_result_t alu_result;
  logic         mul_res_valid;
  logic         mul_res_ready;
  exec_result_t mul_result;

  issue_router i_router (
    .clock         (clock),
    .reset         (reset),
    .issue_valid_i (issue_valid_i),
    .issue_pkt_i   (issue_pkt_i),
    .issue_ready_o (issue_ready_o),
    .alu_valid_o   (alu_valid),
    .mul_valid_o   (mul_valid),
    .pkt_o         (unit_pkt),
    .alu_ready_i   (alu_ready),
    .mul_ready_i   (mul_ready)
  );

  alu_branch_unit i_alu (
    .clock        (clock),
    .reset        (reset),
    .in_valid_i   (alu_valid),
    .pkt_i        (unit_pkt),
    .in_ready_o   (alu_ready),
    .out_valid_o  (alu_res_valid),
    .out_result_o (alu_result),
    .out_ready_i  (alu_res_ready)
  );

  mul_pipe i_mul (
    .clock        (clock),
    .reset        (reset),
    .in_valid_i   (mul_valid),
    .pkt_i        (unit_pkt),
    .in_ready_o   (mul_ready),
    .out_valid_o  (mul_res_valid),
    .out_result_o (mul_result),
    .out_ready_i  (mul_res_ready)
  );

  wb_arbiter i_arb (
    .clock          (clock),
    .reset          (reset),
    .alu_valid_i    (alu_res_valid),
    .alu_result_i   (alu_result),
    .alu_ready_o    (alu_res_ready),
    .mul_valid_i    (mul_res_valid),
    .mul_result_i   (mul_result),
    .mul_ready_o    (mul_res_ready),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_ready_i (result_ready_i)
  );

endmodule

`default_nettype wire

//--- test/exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tb
  import exec_pkg::*, isa_pkg::*;
();

  localparam int TIMEOUT     = 1000;
  localparam int DRAIN_LIMIT = 5000;

  logic         clock = 1'b0;
  logic         reset;
  logic         issue_valid_i;
  issue_pkt_t   issue_pkt_i;
  logic         issue_ready_o;
  logic         result_valid_o;
  exec_result_t result_o;
  logic         result_ready_i;

  // Scoreboard and handshake monitor state
  exec_result_t         exp_res [ROB_DEPTH];
  exec_result_t         exp_now;
  exec_result_t         prev_result;
  logic [ROB_DEPTH-1:0] pending = '0;
  logic                 issue_fire = 1'b0;
  logic                 res_fire = 1'b0;
  int                   cycle_cnt = 0;
  int                   issue_cycle = 0;
  int                   res_cycle = 0;
  int                   ready_mode = 0;
  rob_idx_t             next_rob;

  exec_top i_dut (
    .clock          (clock),
    .reset          (reset),
    .issue_valid_i  (issue_valid_i),
    .issue_pkt_i    (issue_pkt_i),
    .issue_ready_o  (issue_ready_o),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_ready_i (result_ready_i)
  );

  always #50 clock = ~clock;

  task automatic flag_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
    $display("SIMULATION FAILED");
    $display("FAIL time=%0t signal=%s expected=%0h actual=%0h", $time, name, expected, actual);
    $fatal(1, "wrong value on %s", name);
  endtask

  task automatic abort_run(string what);
    $display("SIMULATION FAILED");
    $display("ERROR time=%0t %s", $time, what);
    $fatal(1, "%s", what);
  endtask

  // ============================
  // Reference model
  // ============================
  function automatic logic is_known(logic [31:0] w);
    return (w[6:0] == OP_REG) || (w[6:0] == OP_BRANCH);
  endfunction

  function automatic exec_result_t expected_result(issue_pkt_t p);
    exec_result_t r;
    logic [31:0]  w;
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  imm;
    logic [31:0]  fill;
    logic [63:0]  sa;
    logic [63:0]  sb;
    logic [63:0]  prod;
    logic [2:0]   f3;
    logic [4:0]   sh;
    logic         alt;
    logic         t;
    w = p.inst;
    a = p.src1_val;
    b = p.src2_val;
    f3 = w[14:12];
    sh = b[4:0];
    alt = (w[31:25] == 7'b0100000);
    r = '0;
    r.dest_tag = p.dest_tag;
    r.rob_idx = p.rob_idx;
    if (w[6:0] == OP_BRANCH) begin
      // B-type offset straight from the instruction bit positions
      imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      case (f3)
        3'b000:  t = (a == b);
        3'b001:  t = (a != b);
        3'b100:  t = ($signed(a) < $signed(b));
        3'b101:  t = !($signed(a) < $signed(b));
        3'b110:  t = (a < b);
        3'b111:  t = !(a < b);
        default: t = 1'b0;
      endcase
      r.value = t ? p.pc + imm : p.pc + 32'd4;
      r.is_branch = 1'b1;
      r.taken = t;
      r.mispred = t ^ p.pred_taken;
    end else if (w[31:25] == 7'b0000001) begin
      // MULH signs both, MULHSU only the first
      sa = (f3 == 3'b001 || f3 == 3'b010) ? {{32{a[31]}}, a} : {32'h0, a};
      sb = (f3 == 3'b001) ? {{32{b[31]}}, b} : {32'h0, b};
      prod = sa * sb;
      r.value = (f3 == 3'b000) ? prod[31:0] : prod[63:32];
    end else begin
      fill = a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0;
      case (f3)
        3'b000: r.value = alt ? a - b : a + b;
        3'b001: r.value = a << sh;
        3'b010: r.value = {31'h0, $signed(a) < $signed(b)};
        3'b011: r.value = {31'h0, a < b};
        3'b100: r.value = a ^ b;
        3'b101: r.value = alt ? ((a >> sh) | fill) : (a >> sh);
        3'b110: r.value = a | b;
        3'b111: r.value = a & b;
      endcase
    end
    return r;
  endfunction

  // ============================
  // Scoreboard and monitor
  // ============================
  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    issue_fire <= issue_valid_i && issue_ready_o;
    res_fire <= result_valid_o && result_ready_i;
    prev_result <= result_o;
    if (issue_valid_i && issue_ready_o) begin
      issue_cycle <= cycle_cnt;
    end
    if (result_valid_o && result_ready_i) begin
      res_cycle <= cycle_cnt;
    end
    if (reset) begin
      pending <= '0;
    end else begin
      if (issue_valid_i && issue_ready_o && is_known(issue_pkt_i.inst)) begin
        exp_res[issue_pkt_i.rob_idx] <= expected_result(issue_pkt_i);
        pending[issue_pkt_i.rob_idx] <= 1'b1;
      end
      if (result_valid_o && result_ready_i) begin
        pending[result_o.rob_idx] <= 1'b0;
      end
    end
  end

  assign exp_now = exp_res[result_o.rob_idx];

  a_known: assert property (@(posedge clock) disable iff (reset)
    result_valid_o |-> pending[result_o.rob_idx])
    else abort_run("result appeared for a ROB index with nothing outstanding");

  a_value: assert property (@(posedge clock) disable iff (reset)
    result_valid_o |-> result_o.value == exp_now.value)
    else flag_mismatch("result_o.value", 64'($sampled(exp_now.value)),
                       64'($sampled(result_o.value)));

  a_tag: assert property (@(posedge clock) disable iff (reset)
    result_valid_o |-> result_o.dest_tag == exp_now.dest_tag)
    else flag_mismatch("result_o.dest_tag", 64'($sampled(exp_now.dest_tag)),
                       64'($sampled(result_o.dest_tag)));

  // is_branch, taken and mispred together
  a_flags: assert property (@(posedge clock) disable iff (reset)
    result_valid_o |-> {result_o.is_branch, result_o.taken, result_o.mispred} ==
                       {exp_now.is_branch, exp_now.taken, exp_now.mispred})
    else flag_mismatch("result_o.flags",
                       64'($sampled({exp_now.is_branch, exp_now.taken, exp_now.mispred})),
                       64'($sampled({result_o.is_branch, result_o.taken, result_o.mispred})));

  a_hold_valid: assert property (@(posedge clock) disable iff (reset)
    result_valid_o && !result_ready_i |=> result_valid_o)
    else abort_run("result_valid_o dropped before the result was taken");

  a_hold_data: assert property (@(posedge clock) disable iff (reset)
    result_valid_o && !result_ready_i |=> $stable(result_o))
    else flag_mismatch("result_o", 64'($sampled(prev_result)), 64'($sampled(result_o)));

  // ============================
  // Stimulus
  // ============================
  function automatic xlen_t pick_operand();
    case ($urandom_range(0, 3))
      0:       return xlen_t'($urandom_range(0, 15));
      1:       return ($urandom_range(0, 1) == 1) ? 32'h8000_0000 : 32'hFFFF_FFFF;
      default: return $urandom();
    endcase
  endfunction

  // Kind 0 ALU, 1 multiply, 2 branch, 3 unknown opcode
  function automatic issue_pkt_t make_pkt(int kind, rob_idx_t rob);
    issue_pkt_t  p;
    logic [31:0] rnd;
    logic [12:0] off;
    logic [6:0]  f7;
    logic [6:0]  opc;
    logic [2:0]  f3;
    int          sel;
    p = '0;
    rnd = $urandom();
    p.pc = $urandom() & 32'hFFFF_FFFC;
    p.src1_val = pick_operand();
    p.src2_val = pick_operand();
    p.dest_tag = prf_tag_t'($urandom_range(0, PHYS_REGS - 1));
    p.rob_idx = rob;
    p.pred_taken = ($urandom_range(0, 1) == 1);
    f3 = 3'($urandom_range(0, 7));
    case (kind)
      0: begin
        f7 = FUNCT7_BASE;
        if ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1) begin
          f7 = FUNCT7_ALT;
        end
        p.inst = {f7, rnd[24:15], f3, rnd[11:7], OP_REG};
      end
      1: begin
        f3 = 3'($urandom_range(0, 3));
        p.inst = {FUNCT7_MULDIV, rnd[24:15], f3, rnd[11:7], OP_REG};
      end
      2: begin
        sel = $urandom_range(0, 5);
        f3 = (sel < 2) ? 3'(sel) : 3'(sel + 2);
        off = 13'($urandom_range(0, 8191)) & 13'h1FFE;
        if ($urandom_range(0, 3) == 0) begin
          p.src2_val = p.src1_val;
        end
        p.inst = {off[12], off[10:5], rnd[24:15], f3, off[4:1], off[11], OP_BRANCH};
      end
      default: begin
        case ($urandom_range(0, 2))
          0:       opc = 7'b0000011;
          1:       opc = 7'b0100011;
          default: opc = 7'b0010011;
        endcase
        p.inst = {rnd[31:7], opc};
      end
    endcase
    return p;
  endfunction

  // Called on a falling edge, returns on the falling edge after the handshake
  task automatic issue_one(issue_pkt_t p);
    int waited;
    waited = 0;
    issue_valid_i = 1'b1;
    issue_pkt_i = p;
    @(negedge clock);
    while (!issue_fire) begin
      waited++;
      if (waited > TIMEOUT) abort_run("issue handshake timed out");
      @(negedge clock);
    end
    issue_valid_i = 1'b0;
  endtask

  task automatic wait_rob_free(rob_idx_t idx);
    int waited;
    waited = 0;
    while (pending[idx]) begin
      waited++;
      if (waited > TIMEOUT) abort_run("ROB index was never freed by a result");
      @(negedge clock);
    end
  endtask

  task automatic wait_result();
    int waited;
    waited = 0;
    while (!res_fire) begin
      waited++;
      if (waited > TIMEOUT) abort_run("no result came back for an isolated operation");
      @(negedge clock);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (pending != '0) begin
      waited++;
      if (waited > DRAIN_LIMIT) abort_run("issued packets never completed");
      @(negedge clock);
    end
  endtask

  task automatic measure_latency(int kind, int expected);
    issue_pkt_t p;
    int         got;
    drain();
    wait_rob_free(next_rob);
    p = make_pkt(kind, next_rob);
    next_rob = next_rob + 1'b1;
    issue_one(p);
    wait_result();
    got = res_cycle - issue_cycle;
    assert (got == expected) else flag_mismatch("latency", 64'(expected), 64'(got));
  endtask

  task automatic run_random(int count);
    int         sel;
    int         kind;
    issue_pkt_t p;
    for (int n = 0; n < count; n++) begin
      sel = $urandom_range(0, 19);
      if (sel == 0) begin
        kind = 3;
      end else if (sel < 10) begin
        kind = 0;
      end else if (sel < 15) begin
        kind = 1;
      end else begin
        kind = 2;
      end
      if (kind != 3) begin
        wait_rob_free(next_rob);
      end
      p = make_pkt(kind, next_rob);
      if (kind != 3) begin
        next_rob = next_rob + 1'b1;
      end
      issue_one(p);
      if ($urandom_range(0, 3) == 0) begin
        repeat ($urandom_range(1, 4)) @(negedge clock);
      end
    end
  endtask

  // Complete-stage ready with long low stretches in mode 2
  initial begin
    result_ready_i = 1'b0;
    forever begin
      @(negedge clock);
      case (ready_mode)
        0:       result_ready_i = 1'b1;
        1:       result_ready_i = ($urandom_range(0, 1) == 1);
        default: result_ready_i = ($urandom_range(0, 15) == 0);
      endcase
    end
  end

  initial begin
    void'($urandom(1855));
    reset = 1'b1;
    issue_valid_i = 1'b0;
    issue_pkt_i = '0;
    issue_pkt_i.inst = {25'h0, OP_REG};
    next_rob = '0;
    repeat (10) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    assert (!result_valid_o) else flag_mismatch("result_valid_o", 64'(0), 64'(result_valid_o));
    assert (issue_ready_o) else flag_mismatch("issue_ready_o", 64'(1), 64'(issue_ready_o));

    // Isolated operations with the complete stage always ready
    repeat (2) @(negedge clock);
    measure_latency(0, 2);
    measure_latency(1, MUL_STAGES + 1);
    measure_latency(2, 2);

    ready_mode = 1;
    run_random(200);
    ready_mode = 2;
    run_random(150);
    ready_mode = 0;
    run_random(150);
    ready_mode = 1;
    drain();
    repeat (20) @(negedge clock);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
hw/isa_pkg.sv
hw/exec_pkg.sv
hw/issue_router.sv
hw/alu_branch_unit.sv
hw/mul_pipe.sv
hw/wb_arbiter.sv
hw/exec_top.sv
test/exec_tb.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR)
